// File: Bender.yml
package:
  name: cpu

sources:
  - verilog/cpu_pkg.sv
  - verilog/cpu_decoder.sv
  - verilog/cpu_execute.sv
  - verilog/cpu_registers.sv
  - verilog/cpu_sequencer.sv
  - verilog/cpu_top.sv
  - target: verification
    files:
      - verification/tb_clock.sv
      - verification/cpu_chk.sv
      - verification/cpu_tb.sv

// File: list.f
verilog/cpu_pkg.sv
verilog/cpu_decoder.sv
verilog/cpu_execute.sv
verilog/cpu_registers.sv
verilog/cpu_sequencer.sv
verilog/cpu_top.sv
verification/tb_clock.sv
verification/cpu_chk.sv
verification/cpu_tb.sv

// File: verification/cpu_chk.sv
`timescale 1ns/10ps

module cpu_chk (
    input logic                           clock,
    input logic                           reset,
    input logic                           enable,
    input cpu_pkg::bus_state_t            state_q,
    input logic [cpu_pkg::ADDR_WIDTH-1:0] address,
    input logic [cpu_pkg::DATA_WIDTH-1:0] data_out,
    input logic                           write_enable,
    input logic                           sync
);

    // Opcode fetch is always a read
    no_write_in_fetch: assert property (@(posedge clock) disable iff (reset)
        !(state_q == cpu_pkg::fetch_opcode && write_enable))
        else $error("write strobe during opcode fetch");

    // A stalled cycle repeats the bus outputs
    stall_holds_outputs: assert property (@(posedge clock) disable iff (reset)
        !enable |=> $stable(address) && $stable(data_out) &&
                    $stable(write_enable) && $stable(sync))
        else $error("bus outputs moved while enable was low");

    // Halted core stays off the bus
    no_write_when_halted: assert property (@(posedge clock) disable iff (reset)
        state_q == cpu_pkg::halted |-> !write_enable && !sync)
        else $error("bus activity in halted state");

endmodule

bind cpu_sequencer cpu_chk chk (.*);

// File: verification/cpu_tb.sv
`timescale 1ns/10ps

module cpu_tb;

    localparam logic [15:0] TEST_PC = 16'h0300;
    localparam int PROG_LEN = 60;
    localparam int SYNC_TIMEOUT = 200;
    localparam int NUM_OPS = 51;
    // Kept opcode set for the generator
    localparam logic [7:0] OPS [NUM_OPS] = '{
        8'h09, 8'h05, 8'h0D, 8'h29, 8'h25, 8'h2D, 8'h49, 8'h45, 8'h4D, 8'h69,
        8'h65, 8'h6D, 8'h85, 8'h8D, 8'hA9, 8'hA5, 8'hAD, 8'hE9, 8'hE5, 8'hED,
        8'hA2, 8'hA6, 8'hAE, 8'hA0, 8'hA4, 8'hAC, 8'h86, 8'h8E, 8'h84, 8'h8C,
        8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hBA, 8'hE8, 8'hCA, 8'hC8, 8'h88, 8'h0A,
        8'h2A, 8'h4A, 8'h6A, 8'h18, 8'h38, 8'h58, 8'h78, 8'hD8, 8'hF8, 8'hB8,
        8'h4C
    };

    logic clock, clock_reset, tb_reset, reset, enable;
    logic [7:0] data_in, data_out, debug_opcode, debug_a, debug_x, debug_y;
    logic [7:0] debug_s, debug_status;
    logic [15:0] address, debug_pc;
    logic write_enable, sync;

    logic [7:0] image [0:65535];
    logic [7:0] mem [0:65535];
    logic [7:0] model_mem [0:65535];
    logic [31:0] rng_state = 32'hac58;
    // Reference state
    logic [7:0] ma, mx, my, mp;
    logic [15:0] mpc, store_addr;
    logic store_valid, gaps_on, hung;
    int exp_cycles, cycles, errors, checks, test_errors, test_checks;

    tb_clock clocks (.clock(clock), .reset(clock_reset));

    assign reset = clock_reset | tb_reset;

    cpu_top #(.RESET_PC(TEST_PC)) UUT (.*);

    // Memory reads combinationally, writes at the edge
    assign data_in = mem[address];
    always @(posedge clock) begin
        if (write_enable) begin
            mem[address] <= data_out;
        end
    end

    function automatic logic [31:0] rng();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Random stall cycles, one in four when enabled
    always @(posedge clock) begin
        #2;
        enable <= gaps_on ? (rng() % 4 != 0) : 1'b1;
    end

    // 0 implied, 1 immediate, 2 zero page, 3 absolute, 4 JMP
    function automatic int mode_of(input logic [7:0] op);
        if (op == 8'h4C) return 4;
        if (op[1:0] == 2'b01) begin
            case (op[4:2])
                3'b001:  return 2;
                3'b010:  return 1;
                default: return 3;
            endcase
        end
        if (op inside {8'hA0, 8'hA2}) return 1;
        if (op inside {8'hA4, 8'hA6, 8'h84, 8'h86}) return 2;
        if (op inside {8'hAC, 8'hAE, 8'h8C, 8'h8E}) return 3;
        return 0;
    endfunction

    task automatic check(input string name, input logic [15:0] expected, actual);
        checks++;
        test_checks++;
        if (expected !== actual) begin
            errors++;
            test_errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    // Program image with fill pattern and a halt opcode at the end
    task automatic build_image();
        logic [7:0] op;
        logic [15:0] pc, target;
        int md;
        for (int i = 0; i < 65536; i++) begin
            image[i] = i[7:0] ^ i[15:8] ^ 8'h5A;
        end
        pc = TEST_PC;
        for (int i = 0; i < PROG_LEN; i++) begin
            op = OPS[rng() % NUM_OPS];
            md = mode_of(op);
            image[pc] = op;
            if (md == 4) begin
                // Forward jump over a few halt bytes
                target = pc + 16'd3 + 16'(rng() % 4);
                image[pc + 1] = target[7:0];
                image[pc + 2] = target[15:8];
                for (logic [15:0] j = pc + 3; j != target; j++) begin
                    image[j] = 8'h02;
                end
                pc = target;
            end else if (md == 3) begin
                image[pc + 1] = 8'(rng());
                image[pc + 2] = 8'h10;
                pc = pc + 3;
            end else if (md == 2) begin
                image[pc + 1] = 8'(rng() % 64);
                pc = pc + 2;
            end else if (md == 1) begin
                image[pc + 1] = 8'(rng());
                pc = pc + 2;
            end else begin
                pc = pc + 1;
            end
        end
        image[pc] = 8'h02;
    endtask

    task automatic nz(input logic [7:0] v);
        mp[7] = v[7];
        mp[1] = (v == 8'h00);
    endtask

    // Binary add with carry, SBC passes the complement
    task automatic add_carry(input logic [7:0] v);
        logic [8:0] sum9;
        sum9 = {1'b0, ma} + {1'b0, v} + 9'(mp[0]);
        mp[6] = (ma[7] == v[7]) && (sum9[7] != ma[7]);
        mp[0] = sum9[8];
        ma = sum9[7:0];
        nz(ma);
    endtask

    task automatic model_step();
        logic [7:0] op, b1, b2, val, reg_val;
        logic [15:0] ea;
        logic ci;
        int md;
        op = model_mem[mpc];
        b1 = model_mem[mpc + 1];
        b2 = model_mem[mpc + 2];
        md = mode_of(op);
        ea = (md == 2) ? {8'h00, b1} : {b2, b1};
        val = (md == 1) ? b1 : model_mem[ea];
        ci = mp[0];
        store_valid = 1'b0;
        exp_cycles = (md == 3) ? 4 : (md == 2 || md == 4) ? 3 : 2;
        mpc = mpc + ((md == 0) ? 16'd1 : (md == 3 || md == 4) ? 16'd3 : 16'd2);
        if (md == 4) begin
            mpc = {b2, b1};
        end else if (op inside {8'h85, 8'h8D, 8'h86, 8'h8E, 8'h84, 8'h8C}) begin
            reg_val = (op[1:0] == 2'b01) ? ma : (op[1:0] == 2'b10) ? mx : my;
            model_mem[ea] = reg_val;
            store_addr = ea;
            store_valid = 1'b1;
        end else if (op[1:0] == 2'b01) begin
            case (op[7:5])
                3'd0:    ma = ma | val;
                3'd1:    ma = ma & val;
                3'd2:    ma = ma ^ val;
                3'd3:    add_carry(val);
                3'd5:    ma = val;
                default: add_carry(~val);
            endcase
            nz(ma);
        end else begin
            case (op)
                8'hA2, 8'hA6, 8'hAE: mx = val;
                8'hA0, 8'hA4, 8'hAC: my = val;
                8'hAA: mx = ma;
                8'hA8: my = ma;
                8'h8A: ma = mx;
                8'h98: ma = my;
                8'hBA: mx = 8'hFF;
                8'hE8: mx = mx + 1;
                8'hCA: mx = mx - 1;
                8'hC8: my = my + 1;
                8'h88: my = my - 1;
                // Carry takes the bit shifted out
                8'h0A: {mp[0], ma} = {ma, 1'b0};
                8'h2A: {mp[0], ma} = {ma, ci};
                8'h4A: {ma, mp[0]} = {1'b0, ma};
                8'h6A: {ma, mp[0]} = {ci, ma};
                8'h18, 8'h38: mp[0] = op[5];
                8'h58, 8'h78: mp[2] = op[5];
                8'hD8, 8'hF8: mp[3] = op[5];
                default:      mp[6] = 1'b0;
            endcase
            // N and Z follow the register that was written
            if (op inside {8'hA2, 8'hA6, 8'hAE, 8'hAA, 8'hBA, 8'hE8, 8'hCA}) begin
                nz(mx);
            end else if (op inside {8'hA0, 8'hA4, 8'hAC, 8'hA8, 8'hC8, 8'h88}) begin
                nz(my);
            end else if (op inside {8'h8A, 8'h98, 8'h0A, 8'h2A, 8'h4A, 8'h6A}) begin
                nz(ma);
            end
        end
    endtask

    // Resets the core and both memories
    task automatic restart();
        @(posedge clock);
        #2 tb_reset = 1'b1;
        for (int i = 0; i < 65536; i++) begin
            mem[i] = image[i];
            model_mem[i] = image[i];
        end
        repeat (10) @(posedge clock);
        #2 tb_reset = 1'b0;
        {ma, mx, my, mp} = '0;
        mpc = TEST_PC;
        store_valid = 1'b0;
    endtask

    // Counts enabled cycles until the next enabled sync
    task automatic wait_sync();
        int waited;
        waited = 0;
        @(negedge clock);
        while (!(sync && enable) && !hung) begin
            if (enable) cycles++;
            waited++;
            if (waited > SYNC_TIMEOUT) begin
                hung = 1'b1;
                errors++;
                test_errors++;
                $display("Timeout: sync never came within %0d cycles", SYNC_TIMEOUT);
            end else begin
                @(negedge clock);
            end
        end
    endtask

    task automatic run_program(input string name, input logic gaps);
        start_test();
        gaps_on = gaps;
        restart();
        for (int k = 0; k <= PROG_LEN && !hung; k++) begin
            wait_sync();
            if (!hung) begin
                if (k > 0) begin
                    check({name, " cycles"}, 16'(exp_cycles), 16'(cycles));
                    if (store_valid) begin
                        check({name, " store"}, model_mem[store_addr], mem[store_addr]);
                    end
                end
                check({name, " pc"}, mpc, debug_pc);
                cycles = 1;
                // Previous instruction retires at this edge
                @(negedge clock);
                if (enable) cycles++;
                // Opcode byte of the instruction now in flight
                check({name, " opcode"}, model_mem[mpc], debug_opcode);
                check({name, " a"}, ma, debug_a);
                check({name, " x"}, mx, debug_x);
                check({name, " y"}, my, debug_y);
                check({name, " s"}, 8'hFF, debug_s);
                check({name, " status"}, mp, debug_status);
                if (k < PROG_LEN) model_step();
            end
        end
        finish_test(name);
    endtask

    initial begin
        int seen, diffs;
        enable = 1'b1;
        tb_reset = 1'b0;
        gaps_on = 1'b0;
        hung = 1'b0;
        {errors, checks, cycles, exp_cycles} = '0;
        build_image();
        restart();

        start_test();
        wait_sync();
        if (!hung) begin
            check("reset pc", TEST_PC, debug_pc);
            check("reset a", 8'h00, debug_a);
            check("reset x", 8'h00, debug_x);
            check("reset y", 8'h00, debug_y);
        end
        finish_test("reset");

        if (!hung) run_program("program", 1'b0);
        if (!hung) run_program("enable_gaps", 1'b1);

        // Core sits on the halt opcode from the last run
        if (!hung) begin
            start_test();
            seen = 0;
            diffs = 0;
            repeat (SYNC_TIMEOUT) begin
                @(negedge clock);
                if (sync && enable) seen++;
            end
            if (seen != 0) begin
                errors++;
                test_errors++;
                $display("Sync came back after the unsupported opcode");
            end
            for (int i = 0; i < 65536; i++) begin
                if (mem[i] !== model_mem[i]) diffs++;
            end
            check("halt memory mismatches", 16'd0, 16'(diffs));
            finish_test("halt");
        end

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !hung) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clock,
    output logic reset
);

    // 40 ns period
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // Power-on reset held for 10 cycles
    initial begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        #2 reset = 1'b0;
    end

endmodule

// File: verilog/cpu_decoder.sv
`timescale 1ns/10ps

module cpu_decoder (
    input  logic [cpu_pkg::DATA_WIDTH-1:0] opcode,
    output cpu_pkg::addr_mode_t            mode,
    output cpu_pkg::alu_op_t               alu_op,
    output logic                           load_a,
    output logic                           load_x,
    output logic                           load_y,
    output logic                           is_store,
    output logic                           transfer,
    output logic                           shift_select,
    output logic                           flag_select,
    output logic                           halt
);

    // Opcode family hits, split into selects below
    logic acc_group;
    logic index_group;

    // aaa field picks the accumulator op
    assign alu_op = cpu_pkg::alu_op_t'(opcode[7:5]);

    always_comb begin
        mode         = cpu_pkg::implied;
        acc_group    = 1'b0;
        index_group  = 1'b0;
        transfer     = 1'b0;
        shift_select = 1'b0;
        flag_select  = 1'b0;
        halt         = 1'b0;
        casez (opcode)
            // TXA TYA TAX TAY TSX and the index steps
            8'h8A, 8'h98, 8'hAA, 8'hA8, 8'hBA, 8'hE8, 8'hCA, 8'hC8, 8'h88:
                transfer = 1'b1;
            // CLC SEC CLI SEI CLV CLD SED
            8'h18, 8'h38, 8'h58, 8'h78, 8'hB8, 8'hD8, 8'hF8:
                flag_select = 1'b1;
            8'h4C: mode = cpu_pkg::jump;
            // ASL ROL LSR ROR on A
            8'b0??_010_10: shift_select = 1'b1;
            // cc=01 group, three kept modes
            8'b???_001_01: begin
                mode      = cpu_pkg::zero_page;
                acc_group = 1'b1;
            end
            8'b???_010_01: begin
                mode      = cpu_pkg::immediate;
                acc_group = 1'b1;
            end
            8'b???_011_01: begin
                mode      = cpu_pkg::absolute;
                acc_group = 1'b1;
            end
            // LDY LDX immediate
            8'b101_000_?0: begin
                mode        = cpu_pkg::immediate;
                index_group = 1'b1;
            end
            // STY STX LDY LDX
            8'b10?_001_?0: begin
                mode        = cpu_pkg::zero_page;
                index_group = 1'b1;
            end
            8'b10?_011_?0: begin
                mode        = cpu_pkg::absolute;
                index_group = 1'b1;
            end
            default: halt = 1'b1;
        endcase

        load_a   = 1'b0;
        load_x   = 1'b0;
        load_y   = 1'b0;
        is_store = 1'b0;
        // CMP is dropped, and STA has no immediate form
        if (acc_group) begin
            if (alu_op == cpu_pkg::cmp || (alu_op == cpu_pkg::sta && mode == cpu_pkg::immediate)) begin
                halt = 1'b1;
            end else if (alu_op == cpu_pkg::sta) begin
                is_store = 1'b1;
            end else begin
                load_a = 1'b1;
            end
        end
        // Bit 5 splits loads from stores, bit 1 picks X over Y
        if (index_group) begin
            if (opcode[5]) begin
                load_x = opcode[1];
                load_y = !opcode[1];
            end else begin
                is_store = 1'b1;
            end
        end
    end

endmodule

// File: verilog/cpu_execute.sv
`timescale 1ns/10ps

module cpu_execute (
    input  cpu_pkg::alu_op_t               alu_op,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] a,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] operand,
    input  logic                           carry,
    input  logic [1:0]                     shift_op,
    output logic [cpu_pkg::DATA_WIDTH-1:0] result,
    output logic [cpu_pkg::DATA_WIDTH-1:0] shift_result,
    output logic                           alu_c,
    output logic                           alu_v,
    output logic                           shift_c
);

    logic                           subtract;
    logic [cpu_pkg::DATA_WIDTH-1:0] addend;
    logic [cpu_pkg::DATA_WIDTH:0]   sum;
    logic                           shift_in;

    // Subtraction adds the complemented operand, borrow is inverted carry
    assign subtract = alu_op inside {cpu_pkg::sbc, cpu_pkg::cmp};
    assign addend   = subtract ? ~operand : operand;
    // Binary only, D flag has no effect
    assign sum = {1'b0, a} + {1'b0, addend} + {{cpu_pkg::DATA_WIDTH{1'b0}}, carry};

    always_comb begin
        case (alu_op)
            cpu_pkg::ora:    result = a | operand;
            cpu_pkg::and_op: result = a & operand;
            cpu_pkg::eor:    result = a ^ operand;
            cpu_pkg::adc:    result = sum[cpu_pkg::DATA_WIDTH-1:0];
            cpu_pkg::sbc:    result = sum[cpu_pkg::DATA_WIDTH-1:0];
            cpu_pkg::lda:    result = operand;
            // Never retired into A
            cpu_pkg::sta:    result = a;
            cpu_pkg::cmp:    result = a;
            default:         result = a;
        endcase
    end

    assign alu_c = sum[cpu_pkg::DATA_WIDTH];
    // Signed overflow, both inputs agree and the sum differs
    assign alu_v = (a[cpu_pkg::DATA_WIDTH-1] ^ sum[cpu_pkg::DATA_WIDTH-1]) &
                   (addend[cpu_pkg::DATA_WIDTH-1] ^ sum[cpu_pkg::DATA_WIDTH-1]);

    // Shifter: op bit 0 rotates through carry, bit 1 shifts right
    assign shift_in = shift_op[0] & carry;

    always_comb begin
        if (shift_op[1]) begin
            {shift_result, shift_c} = {shift_in, a};
        end else begin
            {shift_c, shift_result} = {a, shift_in};
        end
    end

endmodule

// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // Data bus and register width
    localparam int DATA_WIDTH = 8;
    // Bus address width, two data bytes
    localparam int ADDR_WIDTH = 16;
    // High address byte for zero-page accesses
    localparam logic [DATA_WIDTH-1:0] ZERO_PAGE_HIGH = '0;

    // Bus sequencer states
    typedef enum logic [2:0] {
        fetch_opcode,
        fetch_operand,
        operand_high,
        data_access,
        halted
    } bus_state_t;

    // Accumulator group op, straight from opcode bits 7:5
    typedef enum logic [2:0] {
        ora,
        and_op,
        eor,
        adc,
        sta,
        lda,
        cmp,
        sbc
    } alu_op_t;

    // Addressing mode of the instruction in flight
    typedef enum logic [2:0] {
        implied,
        immediate,
        zero_page,
        absolute,
        jump
    } addr_mode_t;

    // Bit positions in the status byte
    typedef enum int {
        flag_c = 0,
        flag_z = 1,
        flag_i = 2,
        flag_d = 3,
        flag_v = 6,
        flag_n = 7
    } flag_index_t;

endpackage

// File: verilog/cpu_registers.sv
`timescale 1ns/10ps

module cpu_registers (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           retire,
    input  logic                           load_a,
    input  logic                           load_x,
    input  logic                           load_y,
    input  logic                           transfer,
    input  logic                           shift_select,
    input  logic                           flag_select,
    input  cpu_pkg::alu_op_t               alu_op,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] operand,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] result,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] shift_result,
    input  logic                           alu_c,
    input  logic                           alu_v,
    input  logic                           shift_c,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] opcode,
    output logic [cpu_pkg::DATA_WIDTH-1:0] a,
    output logic [cpu_pkg::DATA_WIDTH-1:0] x,
    output logic [cpu_pkg::DATA_WIDTH-1:0] y,
    output logic [cpu_pkg::DATA_WIDTH-1:0] s,
    output logic [cpu_pkg::DATA_WIDTH-1:0] status,
    output logic [cpu_pkg::DATA_WIDTH-1:0] store_value
);

    logic [cpu_pkg::DATA_WIDTH-1:0] a_q, x_q, y_q, s_q, status_q;
    logic [cpu_pkg::DATA_WIDTH-1:0] next_a, next_x, next_y, next_status;
    // Value that N and Z follow
    logic [cpu_pkg::DATA_WIDTH-1:0] nz_value;
    logic                           set_nz;

    always_comb begin
        next_a      = a_q;
        next_x      = x_q;
        next_y      = y_q;
        next_status = status_q;
        nz_value    = result;
        set_nz      = load_a | load_x | load_y | transfer | shift_select;
        // ALU ops and LDA
        if (load_a) begin
            next_a = result;
            if (alu_op inside {cpu_pkg::adc, cpu_pkg::sbc}) begin
                next_status[cpu_pkg::flag_c] = alu_c;
                next_status[cpu_pkg::flag_v] = alu_v;
            end
        end
        if (load_x) begin
            next_x   = operand;
            nz_value = operand;
        end
        if (load_y) begin
            next_y   = operand;
            nz_value = operand;
        end
        if (shift_select) begin
            next_a   = shift_result;
            nz_value = shift_result;
            next_status[cpu_pkg::flag_c] = shift_c;
        end
        if (transfer) begin
            case (opcode)
                8'h8A:   next_a = x_q;
                8'h98:   next_a = y_q;
                8'hAA:   next_x = a_q;
                8'hBA:   next_x = s_q;
                8'hE8:   next_x = x_q + 1'b1;
                8'hCA:   next_x = x_q - 1'b1;
                8'hA8:   next_y = a_q;
                8'hC8:   next_y = y_q + 1'b1;
                default: next_y = y_q - 1'b1;
            endcase
            // Flags track the destination register
            if (opcode inside {8'h8A, 8'h98}) begin
                nz_value = next_a;
            end else if (opcode inside {8'hAA, 8'hBA, 8'hE8, 8'hCA}) begin
                nz_value = next_x;
            end else begin
                nz_value = next_y;
            end
        end
        if (set_nz) begin
            next_status[cpu_pkg::flag_n] = nz_value[cpu_pkg::DATA_WIDTH-1];
            next_status[cpu_pkg::flag_z] = (nz_value == '0);
        end
        // Set or clear from opcode bit 5, CLV only clears
        if (flag_select) begin
            case (opcode[7:6])
                2'b00:   next_status[cpu_pkg::flag_c] = opcode[5];
                2'b01:   next_status[cpu_pkg::flag_i] = opcode[5];
                2'b10:   next_status[cpu_pkg::flag_v] = 1'b0;
                default: next_status[cpu_pkg::flag_d] = opcode[5];
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            a_q      <= '0;
            x_q      <= '0;
            y_q      <= '0;
            // Top of the stack page, fixed from here on
            s_q      <= '1;
            status_q <= '0;
        end else if (retire) begin
            a_q      <= next_a;
            x_q      <= next_x;
            y_q      <= next_y;
            status_q <= next_status;
        end
    end

    // Store source from opcode bits 1:0, Y X or A
    always_comb begin
        case (opcode[1:0])
            2'b00:   store_value = y_q;
            2'b10:   store_value = x_q;
            default: store_value = a_q;
        endcase
    end

    assign a      = a_q;
    assign x      = x_q;
    assign y      = y_q;
    assign s      = s_q;
    assign status = status_q;

endmodule

// File: verilog/cpu_sequencer.sv
`timescale 1ns/10ps

module cpu_sequencer #(
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_PC = '0
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_in,
    input  cpu_pkg::addr_mode_t            mode,
    input  logic                           is_store,
    input  logic                           halt,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] store_value,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] address,
    output logic [cpu_pkg::DATA_WIDTH-1:0] data_out,
    output logic                           write_enable,
    output logic                           sync,
    output logic [cpu_pkg::DATA_WIDTH-1:0] opcode,
    output logic [cpu_pkg::DATA_WIDTH-1:0] operand,
    output logic                           retire,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] pc
);

    cpu_pkg::bus_state_t            state_q;
    cpu_pkg::bus_state_t            next_state;
    logic [cpu_pkg::ADDR_WIDTH-1:0] pc_q;
    logic [cpu_pkg::ADDR_WIDTH-1:0] next_pc;
    // Instruction byte, held until the next opcode fetch
    logic [cpu_pkg::DATA_WIDTH-1:0] opcode_q;
    // Every enabled cycle samples the bus here
    logic [cpu_pkg::DATA_WIDTH-1:0] data_q;
    // Low byte of an absolute address
    logic [cpu_pkg::DATA_WIDTH-1:0] address_low_q;
    // No instruction to retire before the first fetch
    logic                           started_q;

    always_comb begin
        next_state   = state_q;
        next_pc      = pc_q;
        address      = pc_q;
        write_enable = 1'b0;
        case (state_q)
            cpu_pkg::fetch_opcode: begin
                next_state = cpu_pkg::fetch_operand;
                next_pc    = pc_q + 1'b1;
            end
            // Opcode latched, decoder now valid
            cpu_pkg::fetch_operand: begin
                if (halt) begin
                    next_state = cpu_pkg::halted;
                end else begin
                    // Implied reads the next byte but leaves PC on it
                    if (mode != cpu_pkg::implied) begin
                        next_pc = pc_q + 1'b1;
                    end
                    case (mode)
                        cpu_pkg::zero_page: next_state = cpu_pkg::data_access;
                        cpu_pkg::absolute:  next_state = cpu_pkg::operand_high;
                        cpu_pkg::jump:      next_state = cpu_pkg::operand_high;
                        default:            next_state = cpu_pkg::fetch_opcode;
                    endcase
                end
            end
            cpu_pkg::operand_high: begin
                if (mode == cpu_pkg::jump) begin
                    // High byte taken straight off the bus
                    next_pc    = {data_in, data_q};
                    next_state = cpu_pkg::fetch_opcode;
                end else begin
                    next_pc    = pc_q + 1'b1;
                    next_state = cpu_pkg::data_access;
                end
            end
            cpu_pkg::data_access: begin
                if (mode == cpu_pkg::absolute) begin
                    address = {data_q, address_low_q};
                end else begin
                    address = {cpu_pkg::ZERO_PAGE_HIGH, data_q};
                end
                write_enable = is_store;
                next_state   = cpu_pkg::fetch_opcode;
            end
            // Halted holds until reset
            default: next_state = cpu_pkg::halted;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q   <= cpu_pkg::fetch_opcode;
            pc_q      <= RESET_PC;
            opcode_q  <= '0;
            started_q <= 1'b0;
        end else if (enable) begin
            state_q <= next_state;
            pc_q    <= next_pc;
            if (sync) begin
                opcode_q  <= data_in;
                started_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            data_q <= data_in;
            if (state_q == cpu_pkg::operand_high) begin
                address_low_q <= data_q;
            end
        end
    end

    assign data_out = write_enable ? store_value : '0;
    assign sync     = (state_q == cpu_pkg::fetch_opcode);
    // Completes the previous instruction
    assign retire   = enable & sync & started_q;
    assign opcode   = opcode_q;
    assign operand  = data_q;
    assign pc       = pc_q;

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/10ps

module cpu_top #(
    parameter logic [cpu_pkg::ADDR_WIDTH-1:0] RESET_PC = 16'h0200
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           enable,
    input  logic [cpu_pkg::DATA_WIDTH-1:0] data_in,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] address,
    output logic [cpu_pkg::DATA_WIDTH-1:0] data_out,
    output logic                           write_enable,
    output logic                           sync,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_opcode,
    output logic [cpu_pkg::ADDR_WIDTH-1:0] debug_pc,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_a,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_x,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_y,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_s,
    output logic [cpu_pkg::DATA_WIDTH-1:0] debug_status
);

    // Decoder selects
    cpu_pkg::addr_mode_t mode;
    cpu_pkg::alu_op_t    alu_op;
    logic load_a, load_x, load_y, is_store, transfer, shift_select, flag_select, halt;
    // Sequencer to datapath
    logic [cpu_pkg::DATA_WIDTH-1:0] operand, store_value;
    logic                           retire;
    // Execute results
    logic [cpu_pkg::DATA_WIDTH-1:0] result, shift_result;
    logic                           alu_c, alu_v, shift_c;

    cpu_sequencer #(.RESET_PC(RESET_PC)) sequencer (.opcode(debug_opcode), .pc(debug_pc), .*);

    cpu_decoder decoder (.opcode(debug_opcode), .*);

    // Shift op from opcode bits 6:5, carry in from the status byte
    cpu_execute execute (
        .a(debug_a),
        .carry(debug_status[cpu_pkg::flag_c]),
        .shift_op(debug_opcode[6:5]),
        .*
    );

    cpu_registers registers (
        .opcode(debug_opcode),
        .a(debug_a),
        .x(debug_x),
        .y(debug_y),
        .s(debug_s),
        .status(debug_status),
        .*
    );

endmodule
